// File: compile.f
hw/axi4lite_pkg.sv
hw/request_queue.sv
hw/axi4lite_valid_hold.sv
hw/axi4lite_request_master.sv
hw/pollable_memory_axi4lite_slave.sv
hw/pollable_memory_top.sv
test/pollable_memory_assertions.sv
test/pollable_memory_tb.sv

// File: test/pollable_memory_tb.sv
// ==============================
// testbench for the pollable memory top level; directed, random and
// burst requests, checked by the bound assertion module
// ==============================
`timescale 1ns/1ns

module pollable_memory_tb import axi4lite_pkg::*; ();
	localparam int MEMORY_WORDS = 12;
	localparam int QUEUE_DEPTH = 4;
	localparam int DRAIN_LIMIT = 400;
	localparam int RUN_LIMIT = 20000;
	localparam int RANDOM_REQUESTS = 80;

	logic clock;
	logic reset;
	logic request_strobe;
	access_request_t request;
	logic overflow;
	logic completion_strobe;
	access_completion_t completion;

	int unsigned accepted_count;
	int unsigned completion_count;
	int unsigned timeout_errors = 0;
	logic run_done = 1'b0;

	pollable_memory_top #(
		.MEMORY_WORDS(MEMORY_WORDS),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_dut (
		.clock(clock),
		.reset(reset),
		.request_strobe(request_strobe),
		.request(request),
		.overflow(overflow),
		.completion_strobe(completion_strobe),
		.completion(completion)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// progress counters used only for waiting
	always_ff @(posedge clock) begin
		if (reset) begin
			accepted_count <= 0;
			completion_count <= 0;
		end else begin
			if (request_strobe && !overflow) begin
				accepted_count <= accepted_count + 1;
			end
			if (completion_strobe) begin
				completion_count <= completion_count + 1;
			end
		end
	end

	task automatic send_request(input logic write, input address_t address, input data_t data);
		access_request_t next_request;
		next_request.write = write;
		next_request.address = address;
		next_request.data = data;
		@(posedge clock);
		request_strobe <= 1'b1;
		request <= next_request;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clock);
			request_strobe <= 1'b0;
		end
	endtask

	// wait until every accepted request has completed
	task automatic drain_requests();
		int cycles;
		cycles = 0;
		idle_cycles(1);
		@(negedge clock);
		while (completion_count != accepted_count && cycles < DRAIN_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (completion_count != accepted_count) begin
			timeout_errors++;
			$display("timeout at %0t: only %0d of %0d requests completed", $time,
				completion_count, accepted_count);
		end
	endtask

	initial begin
		int cycles;
		cycles = 0;
		while (!run_done && cycles < RUN_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		if (!run_done) begin
			$display("simulation did not finish within %0d cycles", RUN_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		int gap;
		int unsigned assertion_errors;
		void'($urandom(32'h2a57ac5c));
		reset = 1'b1;
		request_strobe = 1'b0;
		request = '0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		idle_cycles(3);

		// each in-range word reads zero before its first write
		for (int a = 0; a < MEMORY_WORDS; a++) begin
			send_request(1'b0, address_t'(a), '0);
			send_request(1'b1, address_t'(a), 32'h1000_0001 * (a + 1));
			drain_requests();
		end
		// read back what was written
		for (int a = 0; a < MEMORY_WORDS; a++) begin
			send_request(1'b0, address_t'(a), '0);
			drain_requests();
		end
		// decode errors above the memory
		for (int a = MEMORY_WORDS; a < 2**ADDRESS_WIDTH; a++) begin
			send_request(1'b1, address_t'(a), 32'hdead_0000 + a);
			send_request(1'b0, address_t'(a), '0);
			drain_requests();
		end

		for (int i = 0; i < RANDOM_REQUESTS; i++) begin
			send_request(1'($urandom_range(1)), address_t'($urandom_range(15)), $urandom);
			gap = $urandom_range(0, 6);
			idle_cycles(gap);
		end
		drain_requests();

		// back-to-back strobes fill the queue
		for (int i = 0; i < QUEUE_DEPTH + 6; i++) begin
			send_request(1'($urandom_range(1)), address_t'($urandom_range(15)), $urandom);
		end
		drain_requests();
		for (int a = 0; a < 2**ADDRESS_WIDTH; a++) begin
			send_request(1'b0, address_t'(a), '0);
			drain_requests();
		end
		idle_cycles(4);

		run_done = 1'b1;
		assertion_errors = i_dut.i_assertions.failure_count;
		$display("errors: %0d assertion, %0d timeout", assertion_errors, timeout_errors);
		if (assertion_errors == 0 && timeout_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: test/pollable_memory_assertions.sv
// ==============================
// checker bound into the top level; keeps a shadow memory and the
// accepted requests in order, and checks each completion against them
// ==============================
`timescale 1ns/1ns

module pollable_memory_assertions import axi4lite_pkg::*; #(
	parameter int MEMORY_WORDS = 12,
	parameter int QUEUE_DEPTH = 4
) (
	input logic clock,
	input logic reset,
	input logic request_strobe,
	input access_request_t request,
	input logic overflow,
	input logic completion_strobe,
	input access_completion_t completion
);
	// room for a full queue plus the request held by the master
	localparam int PENDING_SLOTS = QUEUE_DEPTH + 2;

	access_request_t pending [PENDING_SLOTS];
	int unsigned pending_read;
	int unsigned pending_write;
	int unsigned pending_count;
	data_t shadow [2**ADDRESS_WIDTH];
	logic request_seen;
	logic request_accepted;
	logic request_retired;
	access_request_t expected;
	data_t expected_read_data;
	int unsigned failure_count = 0;

	assign request_accepted = request_strobe && !overflow;
	assign request_retired = completion_strobe && (pending_count != 0);
	assign expected = pending[pending_read];
	// out of range reads come back as zero
	assign expected_read_data = (completion.address < MEMORY_WORDS) ?
		shadow[completion.address] : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			pending_read <= 0;
			pending_write <= 0;
			pending_count <= 0;
			request_seen <= 1'b0;
			for (int i = 0; i < 2**ADDRESS_WIDTH; i++) begin
				shadow[i] <= '0;
			end
		end else begin
			if (request_strobe) begin
				request_seen <= 1'b1;
			end
			if (request_accepted) begin
				pending[pending_write] <= request;
				pending_write <= (pending_write + 1) % PENDING_SLOTS;
			end
			if (request_retired) begin
				pending_read <= (pending_read + 1) % PENDING_SLOTS;
				// a completed write is what later reads must see
				if (expected.write && (expected.address < MEMORY_WORDS)) begin
					shadow[expected.address] <= expected.data;
				end
			end
			pending_count <= pending_count + (request_accepted ? 1 : 0) -
				(request_retired ? 1 : 0);
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		!request_seen |-> !overflow && !completion_strobe)
	else begin
		failure_count++;
		$error("ERROR %0t: strobe before the first request", $time);
	end

	assert property (@(posedge clock) disable iff (reset)
		completion_strobe |=> !completion_strobe)
	else begin
		failure_count++;
		$error("ERROR %0t: completion strobe longer than one cycle", $time);
	end

	assert property (@(posedge clock) disable iff (reset)
		completion_strobe |-> pending_count != 0)
	else begin
		failure_count++;
		$error("ERROR %0t: completion without an accepted request", $time);
	end

	assert property (@(posedge clock) disable iff (reset)
		completion_strobe |-> completion.write == expected.write &&
			completion.address == expected.address)
	else begin
		failure_count++;
		$error("ERROR %0t: completion out of order, address %0d", $time,
			completion.address);
	end

	assert property (@(posedge clock) disable iff (reset)
		completion_strobe && completion.write |-> completion.data == expected.data)
	else begin
		failure_count++;
		$error("ERROR %0t: write echo %h, expected %h", $time, completion.data,
			expected.data);
	end

	assert property (@(posedge clock) disable iff (reset)
		completion_strobe && !completion.write |-> completion.data == expected_read_data)
	else begin
		failure_count++;
		$error("ERROR %0t: read data %h, expected %h", $time, completion.data,
			expected_read_data);
	end

	assert property (@(posedge clock) disable iff (reset)
		completion_strobe |-> completion.error == (completion.address >= MEMORY_WORDS))
	else begin
		failure_count++;
		$error("ERROR %0t: error flag %b at address %0d", $time, completion.error,
			completion.address);
	end

	// full queue means QUEUE_DEPTH queued, plus possibly one in the master
	assert property (@(posedge clock) disable iff (reset)
		overflow |-> request_strobe && pending_count >= QUEUE_DEPTH)
	else begin
		failure_count++;
		$error("ERROR %0t: overflow with %0d pending", $time, pending_count);
	end

	assert property (@(posedge clock) disable iff (reset)
		request_strobe && pending_count > QUEUE_DEPTH |-> overflow)
	else begin
		failure_count++;
		$error("ERROR %0t: request accepted with %0d pending", $time, pending_count);
	end

endmodule

bind pollable_memory_top pollable_memory_assertions #(
	.MEMORY_WORDS(MEMORY_WORDS),
	.QUEUE_DEPTH(QUEUE_DEPTH)
) i_assertions (
	.clock(clock),
	.reset(reset),
	.request_strobe(request_strobe),
	.request(request),
	.overflow(overflow),
	.completion_strobe(completion_strobe),
	.completion(completion)
);

// File: hw/pollable_memory_top.sv
// ==============================
// request queue, AXI4-lite master and memory slave wired together;
// MEMORY_WORDS and QUEUE_DEPTH are set here and passed down
// ==============================
`timescale 1ns/1ns

module pollable_memory_top import axi4lite_pkg::*; #(
	parameter int MEMORY_WORDS = 12,
	parameter int QUEUE_DEPTH = 4
) (
	input logic clock,
	input logic reset,
	input logic request_strobe,
	input access_request_t request,
	output logic overflow,
	output logic completion_strobe,
	output access_completion_t completion
);
	access_request_t head;
	logic empty;
	logic pop;
	axi4lite_m2s_t m2s;
	axi4lite_s2m_t s2m;

	request_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
		.clock(clock),
		.reset(reset),
		.push(request_strobe),
		.push_request(request),
		.pop(pop),
		.head(head),
		.empty(empty),
		.overflow(overflow)
	);

	axi4lite_request_master i_master (
		.clock(clock),
		.reset(reset),
		.head(head),
		.empty(empty),
		.s2m(s2m),
		.pop(pop),
		.m2s(m2s),
		.completion_strobe(completion_strobe),
		.completion(completion)
	);

	pollable_memory_axi4lite_slave #(.MEMORY_WORDS(MEMORY_WORDS)) i_slave (
		.clock(clock),
		.reset(reset),
		.m2s(m2s),
		.s2m(s2m)
	);

endmodule

// File: hw/pollable_memory_axi4lite_slave.sv
// ==============================
// AXI4-lite word memory slave with independent write and read paths,
// registered pre-response stages and decode errors above MEMORY_WORDS
// ==============================
`timescale 1ns/1ns

module pollable_memory_axi4lite_slave import axi4lite_pkg::*; #(
	parameter int MEMORY_WORDS = 12
) (
	input logic clock,
	input logic reset,
	input axi4lite_m2s_t m2s,
	output axi4lite_s2m_t s2m
);
	data_t memory [MEMORY_WORDS];
	// words never written read back as zero
	logic [MEMORY_WORDS-1:0] word_written;

	// write path
	logic awready;
	logic wready;
	logic aw_captured;
	logic w_captured;
	logic write_pending;
	address_t local_awaddr;
	data_t local_wdata;
	logic write_in_range;
	logic write_commit;
	logic pre_bresp;
	logic pre_bvalid;
	logic bresp;
	logic bvalid;

	// read path
	logic arready;
	logic ar_captured;
	address_t local_araddr;
	logic read_in_range;
	data_t pre_rdata;
	logic pre_rresp;
	logic pre_rvalid;
	data_t rdata;
	logic rresp;
	logic rvalid;

	assign write_in_range = (local_awaddr < MEMORY_WORDS);
	assign read_in_range = (local_araddr < MEMORY_WORDS);
	assign write_commit = aw_captured && w_captured && !write_pending;

	always_comb begin
		s2m.awready = awready;
		s2m.wready = wready;
		s2m.bresp = bresp;
		s2m.bvalid = bvalid;
		s2m.arready = arready;
		s2m.rdata = rdata;
		s2m.rresp = rresp;
		s2m.rvalid = rvalid;
	end

	// payload registers and memory
	always_ff @(posedge clock) begin
		if (m2s.awvalid && awready) begin
			local_awaddr <= m2s.awaddr;
		end
		if (m2s.wvalid && wready) begin
			local_wdata <= m2s.wdata;
		end
		if (m2s.arvalid && arready) begin
			local_araddr <= m2s.araddr;
		end
		if (write_commit && write_in_range) begin
			memory[local_awaddr] <= local_wdata;
		end
		if (ar_captured) begin
			if (read_in_range && word_written[local_araddr]) begin
				pre_rdata <= memory[local_araddr];
			end else begin
				pre_rdata <= '0;
			end
		end
		if (pre_rvalid && !rvalid) begin
			rdata <= pre_rdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			word_written <= '0;
			awready <= 1'b1;
			wready <= 1'b1;
			aw_captured <= 1'b0;
			w_captured <= 1'b0;
			write_pending <= 1'b0;
			pre_bresp <= 1'b0;
			pre_bvalid <= 1'b0;
			bresp <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (m2s.awvalid && awready) begin
				awready <= 1'b0;
				aw_captured <= 1'b1;
			end
			if (m2s.wvalid && wready) begin
				wready <= 1'b0;
				w_captured <= 1'b1;
			end
			// both halves in, commit and stage the response
			if (write_commit) begin
				if (write_in_range) begin
					word_written[local_awaddr] <= 1'b1;
				end
				pre_bresp <= !write_in_range;
				pre_bvalid <= 1'b1;
				write_pending <= 1'b1;
				aw_captured <= 1'b0;
				w_captured <= 1'b0;
			end
			if (bvalid) begin
				if (m2s.bready) begin
					bvalid <= 1'b0;
					bresp <= 1'b0;
					awready <= 1'b1;
					wready <= 1'b1;
					write_pending <= 1'b0;
				end
			end else if (pre_bvalid) begin
				bvalid <= 1'b1;
				bresp <= pre_bresp;
				pre_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			arready <= 1'b1;
			ar_captured <= 1'b0;
			pre_rresp <= 1'b0;
			pre_rvalid <= 1'b0;
			rresp <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (m2s.arvalid && arready) begin
				arready <= 1'b0;
				ar_captured <= 1'b1;
			end
			if (ar_captured) begin
				pre_rresp <= !read_in_range;
				pre_rvalid <= 1'b1;
				ar_captured <= 1'b0;
			end
			if (rvalid) begin
				if (m2s.rready) begin
					rvalid <= 1'b0;
					rresp <= 1'b0;
					arready <= 1'b1;
				end
			end else if (pre_rvalid) begin
				rvalid <= 1'b1;
				rresp <= pre_rresp;
				pre_rvalid <= 1'b0;
			end
		end
	end

endmodule

// File: hw/axi4lite_request_master.sv
// ==============================
// AXI4-lite master that pops one queued request at a time, runs it on the bus
// and emits a completion strobe one cycle after the response transfer
// ==============================
`timescale 1ns/1ns

module axi4lite_request_master import axi4lite_pkg::*; (
	input logic clock,
	input logic reset,
	input access_request_t head,
	input logic empty,
	input axi4lite_s2m_t s2m,
	output logic pop,
	output axi4lite_m2s_t m2s,
	output logic completion_strobe,
	output access_completion_t completion
);
	typedef enum logic [1:0] {
		state_idle,
		state_address,
		state_response
	} master_state_t;

	master_state_t state;
	access_request_t kept_request;
	logic load_write;
	logic load_read;
	logic awvalid;
	logic wvalid;
	logic arvalid;
	address_t awaddr;
	data_t wdata;
	address_t araddr;
	logic bready;
	logic rready;
	logic response_done;

	assign pop = (state == state_idle) && !empty;
	// channels load from the head in the pop cycle, valid rises one cycle later
	assign load_write = pop && head.write;
	assign load_read = pop && !head.write;

	axi4lite_valid_hold #(.payload_t(address_t)) i_aw_hold (
		.clock(clock), .reset(reset),
		.load(load_write), .load_payload(head.address),
		.ready(s2m.awready), .valid(awvalid), .payload(awaddr)
	);

	axi4lite_valid_hold #(.payload_t(data_t)) i_w_hold (
		.clock(clock), .reset(reset),
		.load(load_write), .load_payload(head.data),
		.ready(s2m.wready), .valid(wvalid), .payload(wdata)
	);

	axi4lite_valid_hold #(.payload_t(address_t)) i_ar_hold (
		.clock(clock), .reset(reset),
		.load(load_read), .load_payload(head.address),
		.ready(s2m.arready), .valid(arvalid), .payload(araddr)
	);

	assign bready = (state == state_response) && kept_request.write;
	assign rready = (state == state_response) && !kept_request.write;
	assign response_done = (bready && s2m.bvalid) || (rready && s2m.rvalid);

	always_comb begin
		m2s.awaddr = awaddr;
		m2s.awvalid = awvalid;
		m2s.wdata = wdata;
		m2s.wvalid = wvalid;
		m2s.bready = bready;
		m2s.araddr = araddr;
		m2s.arvalid = arvalid;
		m2s.rready = rready;
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			kept_request <= head;
		end
		if (response_done) begin
			completion.write <= kept_request.write;
			completion.address <= kept_request.address;
			completion.data <= kept_request.write ? kept_request.data : s2m.rdata;
			completion.error <= kept_request.write ? s2m.bresp : s2m.rresp;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_idle;
			completion_strobe <= 1'b0;
		end else begin
			completion_strobe <= response_done;
			case (state)
				state_idle: begin
					if (pop) begin
						state <= state_address;
					end
				end
				state_address: begin
					// all request channels have transferred
					if (!awvalid && !wvalid && !arvalid) begin
						state <= state_response;
					end
				end
				state_response: begin
					if (response_done) begin
						state <= state_idle;
					end
				end
				default: state <= state_idle;
			endcase
		end
	end

endmodule

// File: hw/axi4lite_valid_hold.sv
// ==============================
// holds one channel payload with its valid until the ready handshake;
// instantiated per AXI4-lite request channel
// ==============================
`timescale 1ns/1ns

module axi4lite_valid_hold #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic reset,
	input logic load,
	input payload_t load_payload,
	input logic ready,
	output logic valid,
	output payload_t payload
);
	logic load_accepted;

	// new payloads only while the channel is idle
	assign load_accepted = load && !valid;

	always_ff @(posedge clock) begin
		if (load_accepted) begin
			payload <= load_payload;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= 1'b0;
		end else if (valid) begin
			// transfer on the edge where both are high
			if (ready) begin
				valid <= 1'b0;
			end
		end else if (load) begin
			valid <= 1'b1;
		end
	end

endmodule

// File: hw/request_queue.sv
// ==============================
// circular request buffer between the requester and the bus master;
// a push while full is dropped and flagged on overflow
// ==============================
`timescale 1ns/1ns

module request_queue import axi4lite_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clock,
	input logic reset,
	input logic push,
	input access_request_t push_request,
	input logic pop,
	output access_request_t head,
	output logic empty,
	output logic overflow
);
	localparam int POINTER_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

	access_request_t storage [QUEUE_DEPTH];
	logic [POINTER_WIDTH-1:0] read_pointer;
	logic [POINTER_WIDTH-1:0] write_pointer;
	logic [COUNT_WIDTH-1:0] count;
	logic full;
	logic push_accepted;
	logic pop_accepted;

	assign full = (count == COUNT_WIDTH'(QUEUE_DEPTH));
	assign empty = (count == '0);
	assign push_accepted = push && !full;
	assign pop_accepted = pop && !empty;
	// dropped requests are reported in the cycle they arrive
	assign overflow = push && full;
	assign head = storage[read_pointer];

	always_ff @(posedge clock) begin
		if (push_accepted) begin
			storage[write_pointer] <= push_request;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			read_pointer <= '0;
			write_pointer <= '0;
			count <= '0;
		end else begin
			if (push_accepted) begin
				if (write_pointer == POINTER_WIDTH'(QUEUE_DEPTH - 1)) begin
					write_pointer <= '0;
				end else begin
					write_pointer <= write_pointer + 1'b1;
				end
			end
			if (pop_accepted) begin
				if (read_pointer == POINTER_WIDTH'(QUEUE_DEPTH - 1)) begin
					read_pointer <= '0;
				end else begin
					read_pointer <= read_pointer + 1'b1;
				end
			end
			// simultaneous push and pop leaves the count unchanged
			case ({push_accepted, pop_accepted})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hw/axi4lite_pkg.sv
// ==============================
// bus widths, access request and completion records, and the AXI4-lite
// channel bundles shared by the queue, the master and the memory slave
// ==============================
package axi4lite_pkg;

	// word addressing, one word per address
	localparam int ADDRESS_WIDTH = 4;
	localparam int DATA_WIDTH = 32;

	typedef logic [ADDRESS_WIDTH-1:0] address_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	// data is ignored for reads
	typedef struct packed {
		logic write;
		address_t address;
		data_t data;
	} access_request_t;

	// data holds the written word for writes and the returned word for reads
	typedef struct packed {
		logic write;
		address_t address;
		data_t data;
		logic error;
	} access_completion_t;

	// master to slave
	typedef struct packed {
		address_t awaddr;
		logic awvalid;
		data_t wdata;
		logic wvalid;
		logic bready;
		address_t araddr;
		logic arvalid;
		logic rready;
	} axi4lite_m2s_t;

	// slave to master, single-bit responses
	typedef struct packed {
		logic awready;
		logic wready;
		logic bresp;
		logic bvalid;
		logic arready;
		data_t rdata;
		logic rresp;
		logic rvalid;
	} axi4lite_s2m_t;

endpackage
